//--- common/vdec_pkg.sv
// Decode types for RV32V at VLEN 128 with four 32-bit lanes; only SEW 8/16/32 are encoded
package vdec_pkg;

    // Vector register geometry
    localparam int VLEN_BYTES = 16;
    localparam int NUM_LANES  = 4;
    localparam int VL_W       = 8;
    // Micro-op index, a group spans at most 8 registers
    localparam int UOP_W      = 3;

    // Major opcodes of the vector extension
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111
    } vmajoropcode_t;

    // Arithmetic format held in funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPFVV = 3'b001,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPFVF = 3'b101,
        OPMVX = 3'b110,
        OPCFG = 3'b111
    } vfunct3_t;

    // Integer funct6 space
    typedef enum logic [5:0] {
        VADD  = 6'b000000,
        VSUB  = 6'b000010,
        VAND  = 6'b001001,
        VOR   = 6'b001010,
        VXOR  = 6'b001011,
        VSLL  = 6'b100101,
        VSRL  = 6'b101000,
        VSRA  = 6'b101001,
        VNSRL = 6'b101100,
        VNSRA = 6'b101101
    } vopi_t;

    // Multiply and widening funct6 space, the _W entries are the .w forms
    typedef enum logic [5:0] {
        VWXUNARY0 = 6'b010000,
        VMUL      = 6'b100101,
        VMULH     = 6'b100111,
        VNMSAC    = 6'b101111,
        VWADDU    = 6'b110000,
        VWADD     = 6'b110001,
        VWADDU_W  = 6'b110100,
        VWADD_W   = 6'b110101
    } vopm_t;

    typedef enum logic {VFU_ALU, VFU_MUL} vfu_t;

    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR,
        VALU_SLL, VALU_SRL, VALU_SRA, VALU_MUL, VALU_MULH
    } valuop_t;

    // Encoded as log2 of the element byte count
    typedef enum logic [1:0] {SEW8 = 2'd0, SEW16 = 2'd1, SEW32 = 2'd2} vsew_t;

    // Memory width field of loads and stores
    typedef enum logic [2:0] {WIDTH8 = 3'b000, WIDTH16 = 3'b101, WIDTH32 = 3'b110} width_t;

    typedef enum logic [1:0] {
        MOP_UNIT, MOP_UINDEXED, MOP_STRIDED, MOP_OINDEXED
    } mop_t;

    typedef enum logic [4:0] {
        LUMOP_UNIT         = 5'b00000,
        LUMOP_UNIT_FULLREG = 5'b01000,
        LUMOP_UNIT_MASK    = 5'b01011
    } lumop_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vsetvl_t;

    // Doubled element width, saturates at SEW32 since wider is not encoded
    function automatic vsew_t double_sew(input vsew_t sew);
        return (sew == SEW32) ? SEW32 : vsew_t'(sew + 2'd1);
    endfunction

endpackage

//--- project.f
common/vdec_pkg.sv
vector_decode/opi_decode.sv
vector_decode/opm_decode.sv
rtl/uop_gen.sv
vector_decode/vector_control_unit.sv
verification/tb_vector_control_unit.sv

//--- rtl/uop_gen.sv
// One micro-op per register; issuer holds evl and veew while busy, groups past 8 registers unsupported
`timescale 1ns/10ps

module uop_gen (
    input  logic                                CLK,
    input  logic                                rst_n,
    input  logic                                gen,
    input  logic                                stall,
    input  vdec_pkg::vsew_t                     veew,
    input  logic [vdec_pkg::VL_W-1:0]           evl,
    output logic [vdec_pkg::UOP_W-1:0]          uop_num,
    output logic [vdec_pkg::UOP_W-1:0]          reg_offset,
    output logic [vdec_pkg::NUM_LANES-1:0]      lane_active,
    output logic                                busy
);

    import vdec_pkg::*;

    localparam int BYTES_W    = VL_W + 2;
    localparam int OFS_W      = $clog2(VLEN_BYTES);
    localparam int BLK_W      = BYTES_W - OFS_W + 1;
    localparam int LANE_BYTES = VLEN_BYTES / NUM_LANES;

    logic [BYTES_W-1:0] total_bytes;
    logic [BLK_W-1:0]   blocks;
    logic [UOP_W-1:0]   last_idx;
    logic [OFS_W:0]     tail_bytes;
    logic [UOP_W-1:0]   idx;
    logic               busy_q;
    logic               is_last;

    // Bytes covered by the group, elements times 2^eew
    assign total_bytes = {2'b00, evl} << veew;

    // Registers needed, rounded up
    assign blocks = {1'b0, total_bytes[BYTES_W-1:OFS_W]} + BLK_W'(|total_bytes[OFS_W-1:0]);

    // At least one micro-op even for an empty group
    assign last_idx = (blocks == '0) ? '0 : UOP_W'(blocks - 1'b1);
    assign is_last  = (idx == last_idx);

    // Bytes in the final register, a full register when the count is aligned
    assign tail_bytes = (total_bytes[OFS_W-1:0] != '0) ? {1'b0, total_bytes[OFS_W-1:0]} :
                        (total_bytes == '0)            ? '0 :
                                                         (OFS_W+1)'(VLEN_BYTES);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // Partial mask only on the last micro-op
            lane_active[i] = !is_last || (int'(tail_bytes) > LANE_BYTES * i);
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            idx    <= '0;
            busy_q <= 1'b0;
        end else if (!stall) begin
            if (busy_q) begin
                if (is_last) begin
                    idx    <= '0;
                    busy_q <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end else if (gen && (last_idx != '0)) begin
                // Micro-op 0 went out this cycle
                idx    <= UOP_W'(1);
                busy_q <= 1'b1;
            end
        end
    end

    // Index sits at 0 while idle, so micro-op 0 shows in the accept cycle
    assign uop_num    = idx;
    assign reg_offset = idx;
    assign busy       = busy_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and pass only when the pass message appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_vector_control_unit -f project.f \
    || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_vector_control_unit)"
echo "$sim_out"
echo "$sim_out" | grep -q "^ALL TESTS PASSED$" && exit 0 || exit 1

//--- vector_decode/opi_decode.sv
// Integer vector decode; every listed op goes to the ALU, other funct3 spaces give valid low
`timescale 1ns/10ps

module opi_decode (
    input  vdec_pkg::vopi_t    vopi,
    input  vdec_pkg::vfunct3_t vfunct3,
    output vdec_pkg::vfu_t     vfu,
    output vdec_pkg::valuop_t  valuop,
    output logic               vopunsigned,
    output logic               valid
);

    import vdec_pkg::*;

    logic opi_space;

    // Only the vector-vector, vector-scalar and vector-immediate forms
    assign opi_space = (vfunct3 == OPIVV) || (vfunct3 == OPIVX) || (vfunct3 == OPIVI);

    always_comb begin
        // Integer ops never use the multiplier
        vfu         = VFU_ALU;
        valuop      = VALU_ADD;
        vopunsigned = 1'b0;
        valid       = opi_space;
        case (vopi)
            VADD:  valuop = VALU_ADD;
            VSUB:  valuop = VALU_SUB;
            VAND: begin
                valuop      = VALU_AND;
                vopunsigned = 1'b1;
            end
            VOR: begin
                valuop      = VALU_OR;
                vopunsigned = 1'b1;
            end
            VXOR: begin
                valuop      = VALU_XOR;
                vopunsigned = 1'b1;
            end
            VSLL:  valuop = VALU_SLL;
            // Logical right shifts zero fill
            VSRL, VNSRL: begin
                valuop      = VALU_SRL;
                vopunsigned = 1'b1;
            end
            VSRA, VNSRA: valuop = VALU_SRA;
            default: valid = 1'b0;
        endcase
    end

endmodule

//--- vector_decode/opm_decode.sv
// Multiply and widening-add decode for OPMVV/OPMVX; VWXUNARY0 and other funct6 give valid low
`timescale 1ns/10ps

module opm_decode (
    input  vdec_pkg::vopm_t    vopm,
    input  vdec_pkg::vfunct3_t vfunct3,
    input  vdec_pkg::vsew_t    vsew,
    output vdec_pkg::vfu_t     vfu,
    output vdec_pkg::valuop_t  valuop,
    output logic               vopunsigned,
    output logic               valid,
    output vdec_pkg::vsew_t    veew_src2
);

    import vdec_pkg::*;

    logic opm_space;

    assign opm_space = (vfunct3 == OPMVV) || (vfunct3 == OPMVX);

    // The .w forms already hold a double width vs2
    assign veew_src2 = ((vopm == VWADDU_W) || (vopm == VWADD_W)) ? double_sew(vsew) : vsew;

    always_comb begin
        vfu         = VFU_ALU;
        valuop      = VALU_ADD;
        vopunsigned = 1'b0;
        valid       = opm_space;
        case (vopm)
            VMUL: begin
                vfu    = VFU_MUL;
                valuop = VALU_MUL;
            end
            VMULH: begin
                vfu    = VFU_MUL;
                valuop = VALU_MULH;
            end
            // Multiply-subtract uses the low product
            VNMSAC: begin
                vfu    = VFU_MUL;
                valuop = VALU_MUL;
            end
            // Widening adds run on the ALU adder
            VWADDU, VWADDU_W: vopunsigned = 1'b1;
            VWADD, VWADD_W:   vopunsigned = 1'b0;
            default: valid = 1'b0;
        endcase
    end

endmodule

//--- vector_decode/vector_control_unit.sv
// Combinational RV32V decode; instr, vsew and vl must stay stable while busy is high
`timescale 1ns/10ps

module vector_control_unit (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic [31:0]                    instr,
    input  logic                           in_valid,
    input  logic                           stall,
    input  vdec_pkg::vsew_t                vsew,
    input  logic [vdec_pkg::VL_W-1:0]      vl,
    output logic                           vector,
    output logic                           exec_valid,
    output logic                           busy,
    output logic                           vmask_en,
    output vdec_pkg::vsetvl_t              vsetvl_type,
    output logic [10:0]                    vtype_imm,
    output logic                           vkeepvl,
    output logic [4:0]                     vd_sel,
    output logic [4:0]                     vs1_sel,
    output logic [4:0]                     vs2_sel,
    output logic                           sregwen,
    output logic                           vregwen,
    output logic                           vxin1_use_imm,
    output logic                           vxin1_use_rs1,
    output logic                           vxin2_use_rs2,
    output vdec_pkg::vsew_t                veew_src1,
    output vdec_pkg::vsew_t                veew_src2,
    output vdec_pkg::vsew_t                veew_dest,
    output vdec_pkg::vfu_t                 vfu,
    output vdec_pkg::valuop_t              valuop,
    output logic                           vopunsigned,
    output logic                           vsignext,
    output logic                           vmemdren,
    output logic                           vmemdwen,
    output logic                           vunitstride,
    output logic                           vstrided,
    output logic                           vindexed,
    output logic [vdec_pkg::VL_W-1:0]      mem_evl,
    output logic [vdec_pkg::UOP_W-1:0]     uop_num,
    output logic [vdec_pkg::NUM_LANES-1:0] lane_active
);

    import vdec_pkg::*;

    logic [4:0]       vd, vs1, vs2, vs3;
    logic [5:0]       vfunct6;
    logic [2:0]       nf;
    vmajoropcode_t    vmajoropcode;
    vfunct3_t         vfunct3;
    vopi_t            vopi;
    vopm_t            vopm;
    mop_t             mop;
    lumop_t           lumop;
    width_t           vmem_width;
    vsew_t            vmem_eew, twice_vsew, opm_veew_src2;
    vfu_t             opi_vfu, opm_vfu;
    valuop_t          opi_valuop, opm_valuop;
    logic             opi_unsigned, opm_unsigned, opi_valid, opm_valid;
    logic             is_alu, is_cfg, opi_hit, opm_hit, vmeminstr;
    logic             vwidening, vnarrowing, vmaskldst, vwholereg;
    logic [VL_W-1:0]  mask_evl, wholereg_evl;
    logic [UOP_W-1:0] reg_offset;

    // Store data vs3 shares the vd slot
    // Scalar rd and rs1 sit in the vd and vs1 slots
    assign vd         = instr[11:7];
    assign vs3        = instr[11:7];
    assign vs1        = instr[19:15];
    assign vs2        = instr[24:20];
    assign vfunct6    = instr[31:26];
    assign nf         = instr[31:29];
    assign vmajoropcode = vmajoropcode_t'(instr[6:0]);
    assign vfunct3    = vfunct3_t'(instr[14:12]);
    assign vmem_width = width_t'(instr[14:12]);
    assign vopi       = vopi_t'(vfunct6);
    assign vopm       = vopm_t'(vfunct6);
    assign mop        = mop_t'(instr[27:26]);
    assign lumop      = lumop_t'(instr[24:20]);

    assign vmemdren  = (vmajoropcode == VMOC_LOAD);
    assign vmemdwen  = (vmajoropcode == VMOC_STORE);
    assign vmeminstr = vmemdren || vmemdwen;
    assign is_alu    = (vmajoropcode == VMOC_ALU_CFG);
    assign is_cfg    = is_alu && (vfunct3 == OPCFG);
    assign vector    = vmeminstr || is_alu;
    assign vmask_en  = !instr[25];

    // vset* type from the top two bits
    always_comb begin
        vsetvl_type = NOT_CFG;
        vtype_imm   = '0;
        if (is_cfg) begin
            casez (instr[31:30])
                2'b0?: begin
                    vsetvl_type = VSETVLI;
                    vtype_imm   = instr[30:20];
                end
                2'b11: begin
                    vsetvl_type = VSETIVLI;
                    vtype_imm   = {1'b0, instr[29:20]};
                end
                default: vsetvl_type = VSETVL;
            endcase
        end
    end

    // Both rs1 and rd at x0 keep the current vl
    // The immediate form has no rs1
    assign vkeepvl = is_cfg && (vsetvl_type != VSETIVLI) && (vs1 == '0) && (vd == '0);

    // Scalar writes from vset* and vmv.x.s
    assign sregwen = is_cfg || (is_alu && (vfunct3 == OPMVV) && (vopm == VWXUNARY0));
    assign vregwen = vector && !sregwen && !vmemdwen;

    assign vxin1_use_imm = is_alu && (vfunct3 == OPIVI);
    assign vxin1_use_rs1 = vmeminstr ||
                           (is_alu && ((vfunct3 == OPIVX) || (vfunct3 == OPFVF) ||
                                       (vfunct3 == OPMVX)));

    // The mop bits alias funct6 on arithmetic ops so they count only for memory
    assign vunitstride   = vmeminstr && (mop == MOP_UNIT);
    assign vstrided      = vmeminstr && (mop == MOP_STRIDED);
    assign vindexed      = vmeminstr && ((mop == MOP_UINDEXED) || (mop == MOP_OINDEXED));
    assign vxin2_use_rs2 = vmeminstr && !vindexed;
    assign vmaskldst     = vunitstride && (lumop == LUMOP_UNIT_MASK);
    assign vwholereg     = vunitstride && (lumop == LUMOP_UNIT_FULLREG);

    opi_decode u_opi_decode (
        .vopi        (vopi),
        .vfunct3     (vfunct3),
        .vfu         (opi_vfu),
        .valuop      (opi_valuop),
        .vopunsigned (opi_unsigned),
        .valid       (opi_valid)
    );

    opm_decode u_opm_decode (
        .vopm        (vopm),
        .vfunct3     (vfunct3),
        .vsew        (vsew),
        .vfu         (opm_vfu),
        .valuop      (opm_valuop),
        .vopunsigned (opm_unsigned),
        .valid       (opm_valid),
        .veew_src2   (opm_veew_src2)
    );

    assign opi_hit = is_alu && opi_valid;
    assign opm_hit = is_alu && opm_valid;

    // Exactly one of the three sources may hit
    always_comb begin
        exec_valid  = 1'b1;
        vfu         = VFU_ALU;
        valuop      = VALU_ADD;
        vopunsigned = 1'b0;
        vsignext    = 1'b0;
        case ({opi_hit, opm_hit, vmeminstr})
            3'b100: begin
                vfu         = opi_vfu;
                valuop      = opi_valuop;
                vopunsigned = opi_unsigned;
                vsignext    = !opi_unsigned;
            end
            3'b010: begin
                vfu         = opm_vfu;
                valuop      = opm_valuop;
                vopunsigned = opm_unsigned;
                vsignext    = !opm_unsigned;
            end
            // Address generation as an unsigned add
            3'b001: vopunsigned = 1'b1;
            default: exec_valid = 1'b0;
        endcase
    end

    // Element widths
    assign vmem_eew   = (vmem_width == WIDTH8)  ? SEW8 :
                        (vmem_width == WIDTH16) ? SEW16 : SEW32;
    assign twice_vsew = double_sew(vsew);
    assign vwidening  = opm_hit && (vfunct6[5:4] == 2'b11);
    assign vnarrowing = opi_hit && ((vopi == VNSRL) || (vopi == VNSRA));

    // Store data in vs3 takes the width field unless indexed
    assign veew_src1 = (vmeminstr && !vindexed) ? vmem_eew : vsew;
    // Indexed address vector in vs2 takes the width field
    assign veew_src2 = vindexed   ? vmem_eew :
                       vnarrowing ? twice_vsew :
                       opm_hit    ? opm_veew_src2 : vsew;
    // Indexed accesses fall through to SEW for the data
    assign veew_dest = (vmeminstr && !vindexed) ? vmem_eew :
                       vwidening                ? twice_vsew : vsew;

    // Mask EVL is ceil(vl/8)
    assign mask_evl     = (vl >> 3) + VL_W'(|vl[2:0]);
    // Whole register EVL takes nf as the count of 16 byte registers
    assign wholereg_evl = {1'b0, ({nf, 4'b0000} >> veew_dest)};
    assign mem_evl      = vmaskldst ? mask_evl :
                          vwholereg ? wholereg_evl : vl;

    uop_gen u_uop_gen (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .gen         (in_valid && vector),
        .stall       (stall),
        .veew        (veew_dest),
        .evl         (mem_evl),
        .uop_num     (uop_num),
        .reg_offset  (reg_offset),
        .lane_active (lane_active),
        .busy        (busy)
    );

    // Register selects step with the micro-op
    assign vd_sel  = vd + {2'b00, reg_offset};
    assign vs1_sel = (vmemdwen ? vs3 : vs1) + {2'b00, reg_offset};
    assign vs2_sel = vs2 + {2'b00, reg_offset};

endmodule

//--- verification/tb_vector_control_unit.sv
// Decode table covers SEW 8/16/32 with groups of at most 8 registers; stall patterns are random per row
`timescale 1ns/10ps

module tb_vector_control_unit;

    import vdec_pkg::*;

    localparam int NUM_ROWS = 23;

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          instr;
    logic                 in_valid;
    logic                 stall;
    vsew_t                vsew;
    logic [VL_W-1:0]      vl;
    logic                 vector, exec_valid, busy, vmask_en, vkeepvl;
    vsetvl_t              vsetvl_type;
    logic [10:0]          vtype_imm;
    logic [4:0]           vd_sel, vs1_sel, vs2_sel;
    logic                 sregwen, vregwen, vxin1_use_imm, vxin1_use_rs1, vxin2_use_rs2;
    vsew_t                veew_src1, veew_src2, veew_dest;
    vfu_t                 vfu;
    valuop_t              valuop;
    logic                 vopunsigned, vsignext, vmemdren, vmemdwen;
    logic                 vunitstride, vstrided, vindexed;
    logic [VL_W-1:0]      mem_evl;
    logic [UOP_W-1:0]     uop_num;
    logic [NUM_LANES-1:0] lane_active;

    // Stimulus and expected decode per row
    logic [31:0]     row_instr [NUM_ROWS];
    vsew_t           row_sew   [NUM_ROWS];
    logic [VL_W-1:0] row_vl    [NUM_ROWS];
    logic [15:0]     row_stall [NUM_ROWS];
    // Flag bits from the top are vector exec_valid unsigned signext / mask keepvl sregwen
    // vregwen / use_imm use_rs1 use_rs2 memdren / memdwen unitstride strided indexed
    logic [15:0]     row_flags [NUM_ROWS];
    vfu_t            row_fu    [NUM_ROWS];
    valuop_t         row_op    [NUM_ROWS];
    vsetvl_t         row_cfg   [NUM_ROWS];
    logic [10:0]     row_imm   [NUM_ROWS];
    vsew_t           row_src1  [NUM_ROWS];
    vsew_t           row_src2  [NUM_ROWS];
    vsew_t           row_dest  [NUM_ROWS];
    logic [VL_W-1:0] row_evl   [NUM_ROWS];

    integer seed = 32'h96b0_3398;
    int     n_rows;
    int     cur_row;
    int     checks;
    int     errors;

    vector_control_unit DUT (
        .CLK (clk),
        .*
    );

    always #5 clk = ~clk;

    // Watchdog sized from the table length
    initial begin
        repeat (NUM_ROWS * 20 + 50) @(posedge clk);
        $display("Timeout: decode run still busy after %0d cycles", NUM_ROWS * 20 + 50);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // OP-V arithmetic encoding
    function automatic logic [31:0] op_v(input logic [5:0] f6, input logic vm,
                                         input logic [4:0] vs2, input logic [4:0] vs1,
                                         input logic [2:0] f3, input logic [4:0] vd);
        return {f6, vm, vs2, vs1, f3, vd, VMOC_ALU_CFG};
    endfunction

    // Unmasked load or store encoding with mew clear
    function automatic logic [31:0] mem_op(input logic store, input logic [2:0] nf,
                                           input mop_t mop, input logic [4:0] f24,
                                           input logic [4:0] rs1, input width_t width,
                                           input logic [4:0] vd);
        logic [6:0] opc;
        opc = store ? VMOC_STORE : VMOC_LOAD;
        return {nf, 1'b0, mop, 1'b1, f24, rs1, width, vd, opc};
    endfunction

    // One micro-op per VLEN bytes and never fewer than one
    function automatic int uop_count(input int evl, input vsew_t eew);
        int bytes;
        int n;
        bytes = evl << int'(eew);
        n = (bytes + VLEN_BYTES - 1) / VLEN_BYTES;
        return (n < 1) ? 1 : n;
    endfunction

    // Lanes that hold the remaining bytes of the final register
    function automatic logic [NUM_LANES-1:0] last_lane_mask(input int evl, input vsew_t eew);
        int bytes;
        int rem;
        int lanes;
        bytes = evl << int'(eew);
        rem   = bytes - (uop_count(evl, eew) - 1) * VLEN_BYTES;
        lanes = (rem + (VLEN_BYTES / NUM_LANES) - 1) / (VLEN_BYTES / NUM_LANES);
        return NUM_LANES'((1 << lanes) - 1);
    endfunction

    function automatic logic [4:0] sel_at(input logic [4:0] base, input int off);
        return base + 5'(off);
    endfunction

    // Stall bit of a row for one cycle and no stall past the pattern
    function automatic logic stall_at(input int r, input int cyc);
        return (cyc < 16) ? row_stall[r][cyc] : 1'b0;
    endfunction

    task automatic add_row(input logic [31:0] ins, input vsew_t sew, input int vlen,
                           input logic [15:0] flags, input vfu_t fu, input valuop_t op,
                           input vsetvl_t cfg, input logic [10:0] imm, input vsew_t s1,
                           input vsew_t s2, input vsew_t d, input int evl);
        row_instr[n_rows] = ins;
        row_sew[n_rows]   = sew;
        row_vl[n_rows]    = VL_W'(vlen);
        // Roughly one stall cycle in four
        row_stall[n_rows] = 16'($random(seed) & $random(seed));
        row_flags[n_rows] = flags;
        row_fu[n_rows]    = fu;
        row_op[n_rows]    = op;
        row_cfg[n_rows]   = cfg;
        row_imm[n_rows]   = imm;
        row_src1[n_rows]  = s1;
        row_src2[n_rows]  = s2;
        row_dest[n_rows]  = d;
        row_evl[n_rows]   = VL_W'(evl);
        n_rows++;
    endtask

    task automatic load_table();
        n_rows = 0;
        // vadd and vsub in the three operand forms with one masked
        add_row(op_v(VADD, 1'b1, 5'd8, 5'd12, OPIVV, 5'd4), SEW32, 10, 16'hD100,
                VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW32, SEW32, SEW32, 10);
        add_row(op_v(VADD, 1'b0, 5'd6, 5'd5, OPIVX, 5'd2), SEW16, 20, 16'hD940,
                VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW16, SEW16, SEW16, 20);
        add_row(op_v(VADD, 1'b1, 5'd3, 5'd5, OPIVI, 5'd1), SEW8, 16, 16'hD180,
                VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW8, SEW8, 16);
        add_row(op_v(VSUB, 1'b1, 5'd20, 5'd30, OPIVV, 5'd10), SEW32, 4, 16'hD100,
                VFU_ALU, VALU_SUB, NOT_CFG, 11'h0, SEW32, SEW32, SEW32, 4);
        add_row(op_v(VSUB, 1'b1, 5'd9, 5'd11, OPIVX, 5'd14), SEW8, 33, 16'hD140,
                VFU_ALU, VALU_SUB, NOT_CFG, 11'h0, SEW8, SEW8, SEW8, 33);
        add_row(op_v(VSUB, 1'b1, 5'd2, 5'd7, OPIVI, 5'd6), SEW16, 8, 16'hD180,
                VFU_ALU, VALU_SUB, NOT_CFG, 11'h0, SEW16, SEW16, SEW16, 8);
        // Multiplier and widening or narrowing widths
        add_row(op_v(VMUL, 1'b1, 5'd16, 5'd17, OPMVV, 5'd18), SEW32, 6, 16'hD100,
                VFU_MUL, VALU_MUL, NOT_CFG, 11'h0, SEW32, SEW32, SEW32, 6);
        add_row(op_v(VWADD, 1'b1, 5'd4, 5'd8, OPMVV, 5'd12), SEW16, 16, 16'hD100,
                VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW16, SEW16, SEW32, 16);
        add_row(op_v(VWADDU, 1'b1, 5'd4, 5'd7, OPMVX, 5'd8), SEW8, 20, 16'hE140,
                VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW8, SEW16, 20);
        add_row(op_v(VNSRL, 1'b1, 5'd24, 5'd3, OPIVI, 5'd2), SEW16, 12, 16'hE180,
                VFU_ALU, VALU_SRL, NOT_CFG, 11'h0, SEW16, SEW32, SEW16, 12);
        // Keep-vl needs x0 sources outside vsetivli
        add_row({1'b0, 11'h0d1, 5'd6, OPCFG, 5'd5, VMOC_ALU_CFG}, SEW32, 8, 16'h8A00,
                VFU_ALU, VALU_ADD, VSETVLI, 11'h0d1, SEW32, SEW32, SEW32, 8);
        add_row({1'b0, 11'h010, 5'd0, OPCFG, 5'd0, VMOC_ALU_CFG}, SEW8, 16, 16'h8E00,
                VFU_ALU, VALU_ADD, VSETVLI, 11'h010, SEW8, SEW8, SEW8, 16);
        add_row({2'b11, 10'h0c2, 5'd0, OPCFG, 5'd0, VMOC_ALU_CFG}, SEW16, 8, 16'h8A00,
                VFU_ALU, VALU_ADD, VSETIVLI, 11'h0c2, SEW16, SEW16, SEW16, 8);
        add_row({1'b1, 6'd0, 5'd7, 5'd0, OPCFG, 5'd0, VMOC_ALU_CFG}, SEW32, 4, 16'h8E00,
                VFU_ALU, VALU_ADD, VSETVL, 11'h0, SEW32, SEW32, SEW32, 4);
        // Unit, strided, indexed, mask and whole register loads
        add_row(mem_op(1'b0, 3'd0, MOP_UNIT, LUMOP_UNIT, 5'd10, WIDTH16, 5'd8), SEW32, 20,
                16'hE174, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW16, SEW32, SEW16, 20);
        add_row(mem_op(1'b0, 3'd0, MOP_STRIDED, 5'd3, 5'd11, WIDTH32, 5'd4), SEW8, 8,
                16'hE172, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW32, SEW8, SEW32, 8);
        add_row(mem_op(1'b0, 3'd0, MOP_UINDEXED, 5'd12, 5'd13, WIDTH8, 5'd16), SEW32, 8,
                16'hE151, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW32, SEW8, SEW32, 8);
        add_row(mem_op(1'b0, 3'd0, MOP_UNIT, LUMOP_UNIT_MASK, 5'd2, WIDTH8, 5'd1), SEW8, 17,
                16'hE174, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW8, SEW8, 3);
        add_row(mem_op(1'b0, 3'd2, MOP_UNIT, LUMOP_UNIT_FULLREG, 5'd2, WIDTH32, 5'd6), SEW8,
                50, 16'hE174, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW32, SEW8, SEW32, 8);
        // Stores read vs3 through the vs1 select
        add_row(mem_op(1'b1, 3'd0, MOP_UNIT, LUMOP_UNIT, 5'd9, WIDTH8, 5'd3), SEW16, 24,
                16'hE06C, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW16, SEW8, 24);
        add_row(mem_op(1'b1, 3'd0, MOP_UNIT, LUMOP_UNIT_MASK, 5'd9, WIDTH8, 5'd0), SEW32, 100,
                16'hE06C, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW32, SEW8, 13);
        add_row(mem_op(1'b1, 3'd0, MOP_UINDEXED, 5'd5, 5'd9, WIDTH16, 5'd7), SEW8, 20,
                16'hE049, VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW16, SEW8, 20);
        // Scalar addi with a vl that would span several registers
        add_row(32'h00a5_0513, SEW8, 40, 16'h0800,
                VFU_ALU, VALU_ADD, NOT_CFG, 11'h0, SEW8, SEW8, SEW8, 40);
    endtask

    task automatic check_fu(input string name, input vfu_t got, input vfu_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input valuop_t got, input valuop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_sew(input string name, input vsew_t got, input vsew_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_cfg(input string name, input vsetvl_t got, input vsetvl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_bits(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_decode(input int r);
        check_bits("flags", {vector, exec_valid, vopunsigned, vsignext, vmask_en, vkeepvl,
                             sregwen, vregwen, vxin1_use_imm, vxin1_use_rs1, vxin2_use_rs2,
                             vmemdren, vmemdwen, vunitstride, vstrided, vindexed},
                   row_flags[r]);
        check_fu("vfu", vfu, row_fu[r]);
        check_op("valuop", valuop, row_op[r]);
        check_cfg("vsetvl_type", vsetvl_type, row_cfg[r]);
        check_word("vtype_imm", 32'(vtype_imm), 32'(row_imm[r]));
        check_sew("veew_src1", veew_src1, row_src1[r]);
        check_sew("veew_src2", veew_src2, row_src2[r]);
        check_sew("veew_dest", veew_dest, row_dest[r]);
        check_word("mem_evl", 32'(mem_evl), 32'(row_evl[r]));
    endtask

    // Follows the micro-ops of one row and advances only on edges without stall
    task automatic run_uops(input int r);
        int               count;
        int               idx;
        int               cyc;
        logic             done;
        logic [NUM_LANES-1:0] tail_mask;
        logic [4:0]       vd_f;
        logic [4:0]       vs1_f;
        logic [4:0]       vs2_f;
        count     = uop_count(int'(row_evl[r]), row_dest[r]);
        tail_mask = last_lane_mask(int'(row_evl[r]), row_dest[r]);
        idx       = 0;
        cyc       = 0;
        done      = 1'b0;
        vd_f      = row_instr[r][11:7];
        // Stores take vs3 from the vd slot
        vs1_f     = row_flags[r][3] ? row_instr[r][11:7] : row_instr[r][19:15];
        vs2_f     = row_instr[r][24:20];
        while (!done) begin
            check_word("uop_num", 32'(uop_num), 32'(idx));
            check_word("vd_sel", 32'(vd_sel), 32'(sel_at(vd_f, idx)));
            check_word("vs1_sel", 32'(vs1_sel), 32'(sel_at(vs1_f, idx)));
            check_word("vs2_sel", 32'(vs2_sel), 32'(sel_at(vs2_f, idx)));
            check_word("lane_active", 32'(lane_active),
                       (idx == count - 1) ? 32'(tail_mask) : 32'((1 << NUM_LANES) - 1));
            check_bits("busy", 16'(busy), 16'(idx != 0));
            if (!stall) begin
                if (idx == count - 1) begin
                    done = 1'b1;
                end else begin
                    idx++;
                end
            end
            @(posedge clk);
            if (done) begin
                in_valid <= 1'b0;
            end
            cyc++;
            stall <= stall_at(r, cyc);
            @(negedge clk);
        end
        check_bits("busy", 16'(busy), 16'h0);
        check_word("uop_num", 32'(uop_num), 32'h0);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        instr    = '0;
        in_valid = 1'b0;
        stall    = 1'b0;
        vsew     = SEW8;
        vl       = '0;
        checks   = 0;
        errors   = 0;
        cur_row  = -1;
        load_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // Idle state out of reset
        check_bits("busy", 16'(busy), 16'h0);
        check_word("uop_num", 32'(uop_num), 32'h0);
        for (int r = 0; r < n_rows; r++) begin
            cur_row = r;
            @(posedge clk);
            instr    <= row_instr[r];
            vsew     <= row_sew[r];
            vl       <= row_vl[r];
            in_valid <= 1'b1;
            stall    <= row_flags[r][15] ? stall_at(r, 0) : 1'b0;
            @(negedge clk);
            check_decode(r);
            if (row_flags[r][15]) begin
                run_uops(r);
            end else begin
                // Non-vector opcode never starts a group
                @(posedge clk);
                in_valid <= 1'b0;
                @(negedge clk);
                check_bits("busy", 16'(busy), 16'h0);
                check_word("uop_num", 32'(uop_num), 32'h0);
            end
        end
        $display("Decode run done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
